/* mbox_pkg.sv */
// Sizes and encodings shared by the mailbox design and its testbench
// The mailbox SRAM stores one even-parity bit above each data word
package mbox_pkg;

    // Data path and mailbox SRAM geometry
    localparam int MBOX_DATA_W = 32;
    localparam int MBOX_ADDR_W = 6;
    localparam int MBOX_SRAM_W = MBOX_DATA_W + 1;

    // Receive buffer depth, also the credits first granted to the SoC
    localparam int RX_DEPTH = 4;

    // Controller skid depth and the credits it grants the receive buffer
    localparam int CTRL_CREDITS = 2;

    // Fuse writes needed before fuse_done is honoured
    localparam int FUSE_WORDS = 4;

    typedef enum logic [1:0] {
        BOOT_IDLE,
        BOOT_FUSE,
        BOOT_BRKPOINT,
        BOOT_READY
    } boot_state_t;

endpackage

/* mbox_credit_if.sv */
// Credit-based word channel from the receive buffer to the controller
// The source sends a word only while it holds a credit
interface mbox_credit_if
    import mbox_pkg::*;
();

    logic                   valid;
    logic [MBOX_DATA_W-1:0] data;
    logic                   last;
    // One pulse per freed sink entry
    logic                   credit;

    modport src (
        output valid,
        output data,
        output last,
        input  credit
    );

    modport sink (
        input  valid,
        input  data,
        input  last,
        output credit
    );

endinterface

/* soc_ifc_rx.sv */
// Assumes the SoC writes only while holding a credit, a write into a full buffer is dropped
// SoC credits start only once ready_for_mb_processing is seen high
module soc_ifc_rx
    import mbox_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ready_for_mb_processing,
    input  logic                   soc_valid,
    input  logic [MBOX_DATA_W-1:0] soc_data,
    input  logic                   soc_last,
    output logic                   soc_credit,
    mbox_credit_if.src             credit_if
);
    typedef logic [$clog2(RX_DEPTH)-1:0]         ptr_t;
    typedef logic [$clog2(RX_DEPTH + 1)-1:0]     cnt_t;
    typedef logic [$clog2(CTRL_CREDITS + 1)-1:0] crd_t;

    logic [MBOX_DATA_W-1:0] data_mem [RX_DEPTH];
    logic                   last_mem [RX_DEPTH];
    ptr_t                   wr_ptr;
    ptr_t                   rd_ptr;
    cnt_t                   fill;
    crd_t                   ctrl_crd;
    cnt_t                   soc_owed;
    logic                   init_done;
    logic                   init_grant;
    logic                   push;
    logic                   pop;

    assign push       = soc_valid && (fill != cnt_t'(RX_DEPTH));
    // Forward the head entry whenever the controller has room
    assign pop        = (fill != '0) && (ctrl_crd != '0);
    assign init_grant = ready_for_mb_processing && !init_done;

    assign credit_if.valid = pop;
    assign credit_if.data  = data_mem[rd_ptr];
    assign credit_if.last  = last_mem[rd_ptr];

    // One credit per cycle while any are owed
    assign soc_credit = (soc_owed != '0);

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            data_mem[wr_ptr] <= soc_data;
            last_mem[wr_ptr] <= soc_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            ctrl_crd  <= '0;
            soc_owed  <= '0;
            init_done <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == ptr_t'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == ptr_t'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            fill     <= fill + cnt_t'(push) - cnt_t'(pop);
            ctrl_crd <= ctrl_crd + crd_t'(credit_if.credit) - crd_t'(pop);
            if (init_grant)
                init_done <= 1'b1;
            // Initial grant once, then one credit back per forwarded word
            soc_owed <= soc_owed + (init_grant ? cnt_t'(RX_DEPTH) : '0)
                        + cnt_t'(pop) - cnt_t'(soc_credit);
        end
    end

endmodule

/* boot_fsm.sv */
// Fuse words are counted only, their values are not kept
// Any fuse write outside the fuse phase is a sticky non-fatal error
module boot_fsm
    import mbox_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic fuse_wr,
    input  logic fuse_done,
    input  logic brkpoint,
    output logic ready_for_fuses,
    output logic ready_for_mb_processing,
    output logic error_non_fatal
);
    typedef logic [$clog2(FUSE_WORDS + 1)-1:0] fuse_cnt_t;

    boot_state_t state;
    boot_state_t state_nxt;
    fuse_cnt_t   fuse_cnt;
    logic        fuses_complete;

    assign fuses_complete = (fuse_cnt == fuse_cnt_t'(FUSE_WORDS));

    always_comb
    begin
        state_nxt = state;
        case (state)
            BOOT_IDLE:
                state_nxt = BOOT_FUSE;
            BOOT_FUSE:
            begin
                // fuse_done is ignored until all fuse words arrived
                if (fuse_done && fuses_complete)
                    state_nxt = brkpoint ? BOOT_BRKPOINT : BOOT_READY;
            end
            BOOT_BRKPOINT:
            begin
                if (!brkpoint)
                    state_nxt = BOOT_READY;
            end
            default:
                state_nxt = state;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state           <= BOOT_IDLE;
            fuse_cnt        <= '0;
            error_non_fatal <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (state == BOOT_FUSE && fuse_wr && !fuses_complete)
                fuse_cnt <= fuse_cnt + 1'b1;
            // Fuses are locked outside the fuse phase
            if (fuse_wr && state != BOOT_FUSE)
                error_non_fatal <= 1'b1;
        end
    end

    assign ready_for_fuses         = (state == BOOT_FUSE);
    assign ready_for_mb_processing = (state == BOOT_READY);

endmodule

/* mbox_ctrl.sv */
// Single-port mailbox SRAM with one-cycle read latency, reads win over writes
// No writes while mailbox_data_avail is high, soc_rd_done rewinds the write pointer
module mbox_ctrl
    import mbox_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   soc_rd_en,
    input  logic [MBOX_ADDR_W-1:0] soc_rd_addr,
    input  logic                   soc_rd_done,
    input  logic [MBOX_SRAM_W-1:0] mbox_sram_rdata,
    mbox_credit_if.sink            credit_if,
    output logic                   mbox_sram_cs,
    output logic                   mbox_sram_we,
    output logic [MBOX_ADDR_W-1:0] mbox_sram_addr,
    output logic [MBOX_SRAM_W-1:0] mbox_sram_wdata,
    output logic                   soc_rd_valid,
    output logic [MBOX_DATA_W-1:0] soc_rd_data,
    output logic                   mailbox_data_avail,
    output logic                   error_fatal
);
    typedef logic [$clog2(CTRL_CREDITS)-1:0]     sptr_t;
    typedef logic [$clog2(CTRL_CREDITS + 1)-1:0] scnt_t;

    logic [MBOX_DATA_W-1:0] skid_data [CTRL_CREDITS];
    logic                   skid_last [CTRL_CREDITS];
    sptr_t                  skid_wr;
    sptr_t                  skid_rd;
    scnt_t                  skid_fill;
    scnt_t                  init_left;
    logic                   init_pulse;
    logic [MBOX_ADDR_W-1:0] wr_addr;
    logic [MBOX_ADDR_W-1:0] rd_addr_q;
    logic                   rd_pend;
    logic                   wr_go;
    logic [MBOX_DATA_W-1:0] head_data;

    assign head_data = skid_data[skid_rd];

    // Drain the skid only when no read owns the port
    assign wr_go = (skid_fill != '0) && !rd_pend && !mailbox_data_avail;

    // Freed entry is credited in the write cycle itself
    assign credit_if.credit = wr_go || init_pulse;

    assign mbox_sram_cs    = rd_pend || wr_go;
    assign mbox_sram_we    = wr_go;
    assign mbox_sram_addr  = rd_pend ? rd_addr_q : wr_addr;
    // Even parity over the stored word
    assign mbox_sram_wdata = {^head_data, head_data};
    assign soc_rd_data     = mbox_sram_rdata[MBOX_DATA_W-1:0];

    always_ff @(posedge clk)
    begin
        if (credit_if.valid)
        begin
            skid_data[skid_wr] <= credit_if.data;
            skid_last[skid_wr] <= credit_if.last;
        end
        if (soc_rd_en)
            rd_addr_q <= soc_rd_addr;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            skid_wr            <= '0;
            skid_rd            <= '0;
            skid_fill          <= '0;
            init_left          <= scnt_t'(CTRL_CREDITS);
            init_pulse         <= 1'b0;
            wr_addr            <= '0;
            rd_pend            <= 1'b0;
            soc_rd_valid       <= 1'b0;
            mailbox_data_avail <= 1'b0;
            error_fatal        <= 1'b0;
        end
        else
        begin
            // Initial credits, one per cycle after reset
            init_pulse <= (init_left != '0);
            if (init_left != '0)
                init_left <= init_left - 1'b1;

            if (credit_if.valid)
                skid_wr <= (skid_wr == sptr_t'(CTRL_CREDITS - 1)) ? '0 : skid_wr + 1'b1;
            if (wr_go)
                skid_rd <= (skid_rd == sptr_t'(CTRL_CREDITS - 1)) ? '0 : skid_rd + 1'b1;
            skid_fill <= skid_fill + scnt_t'(credit_if.valid) - scnt_t'(wr_go);

            rd_pend      <= soc_rd_en;
            soc_rd_valid <= rd_pend;

            if (soc_rd_done)
            begin
                mailbox_data_avail <= 1'b0;
                wr_addr            <= '0;
            end
            else if (wr_go)
            begin
                wr_addr <= wr_addr + 1'b1;
                if (skid_last[skid_rd])
                    mailbox_data_avail <= 1'b1;
            end

            // Odd parity on readback means a corrupted word
            if (soc_rd_valid && ^mbox_sram_rdata)
                error_fatal <= 1'b1;
        end
    end

endmodule

/* mbox_top.sv */
// Mailbox subsystem top, the mailbox SRAM sits outside on the mbox_sram_* ports
// The SoC may write only while it holds credits from soc_credit
module mbox_top
    import mbox_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fuse_wr,
    input  logic                   fuse_done,
    input  logic                   brkpoint,
    output logic                   ready_for_fuses,
    output logic                   ready_for_mb_processing,
    input  logic                   soc_valid,
    input  logic [MBOX_DATA_W-1:0] soc_data,
    input  logic                   soc_last,
    output logic                   soc_credit,
    input  logic                   soc_rd_en,
    input  logic [MBOX_ADDR_W-1:0] soc_rd_addr,
    input  logic                   soc_rd_done,
    output logic                   soc_rd_valid,
    output logic [MBOX_DATA_W-1:0] soc_rd_data,
    output logic                   mailbox_data_avail,
    output logic                   mbox_sram_cs,
    output logic                   mbox_sram_we,
    output logic [MBOX_ADDR_W-1:0] mbox_sram_addr,
    output logic [MBOX_SRAM_W-1:0] mbox_sram_wdata,
    input  logic [MBOX_SRAM_W-1:0] mbox_sram_rdata,
    output logic                   error_fatal,
    output logic                   error_non_fatal
);

    mbox_credit_if crd_if ();

    boot_fsm u_boot_fsm (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .fuse_wr                 (fuse_wr),
        .fuse_done               (fuse_done),
        .brkpoint                (brkpoint),
        .ready_for_fuses         (ready_for_fuses),
        .ready_for_mb_processing (ready_for_mb_processing),
        .error_non_fatal         (error_non_fatal)
    );

    soc_ifc_rx u_soc_ifc_rx (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .ready_for_mb_processing (ready_for_mb_processing),
        .soc_valid               (soc_valid),
        .soc_data                (soc_data),
        .soc_last                (soc_last),
        .soc_credit              (soc_credit),
        .credit_if               (crd_if.src)
    );

    mbox_ctrl u_mbox_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .soc_rd_en          (soc_rd_en),
        .soc_rd_addr        (soc_rd_addr),
        .soc_rd_done        (soc_rd_done),
        .mbox_sram_rdata    (mbox_sram_rdata),
        .credit_if          (crd_if.sink),
        .mbox_sram_cs       (mbox_sram_cs),
        .mbox_sram_we       (mbox_sram_we),
        .mbox_sram_addr     (mbox_sram_addr),
        .mbox_sram_wdata    (mbox_sram_wdata),
        .soc_rd_valid       (soc_rd_valid),
        .soc_rd_data        (soc_rd_data),
        .mailbox_data_avail (mailbox_data_avail),
        .error_fatal        (error_fatal)
    );

endmodule

/* mbox_tb_services.sv */
// Mailbox SRAM model, read data registered one cycle after the request
// flip_en inverts the stored parity bit at flip_addr
module mbox_tb_services
    import mbox_pkg::*;
(
    input  logic                   clk,
    input  logic                   cs,
    input  logic                   we,
    input  logic [MBOX_ADDR_W-1:0] addr,
    input  logic [MBOX_SRAM_W-1:0] wdata,
    output logic [MBOX_SRAM_W-1:0] rdata,
    input  logic                   flip_en,
    input  logic [MBOX_ADDR_W-1:0] flip_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [MBOX_SRAM_W-1:0] mem [2**MBOX_ADDR_W];

    always_ff @(posedge clk)
    begin
        if (cs && we)
            mem[addr] <= wdata;
        else if (cs)
            rdata <= mem[addr];
        // Fault injection on the parity bit only
        if (flip_en)
            mem[flip_addr][MBOX_SRAM_W-1] <= ~mem[flip_addr][MBOX_SRAM_W-1];
    end

endmodule

/* mbox_top_assertions.sv */
// Protocol checks bound into mbox_top, failures are counted in fail_count
// SoC credits are tracked here from soc_credit and soc_valid
module mbox_top_assertions
    import mbox_pkg::*;
(
    input logic                   clk,
    input logic                   rst_n,
    input logic                   fuse_wr,
    input logic                   brkpoint,
    input logic                   ready_for_fuses,
    input logic                   ready_for_mb_processing,
    input logic                   soc_valid,
    input logic                   soc_credit,
    input logic                   soc_rd_en,
    input logic                   soc_rd_valid,
    input logic                   mailbox_data_avail,
    input logic                   mbox_sram_we,
    input logic [MBOX_SRAM_W-1:0] mbox_sram_rdata,
    input logic                   error_fatal,
    input logic                   error_non_fatal
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;
    int soc_crd;

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            soc_crd <= 0;
        else
            soc_crd <= soc_crd + int'(soc_credit) - int'(soc_valid);
    end

    assert property (@(posedge clk) disable iff (!rst_n) soc_valid |-> soc_crd > 0)
        else begin $error("SoC write without a credit"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n) soc_crd >= 0 && soc_crd <= RX_DEPTH)
        else begin $error("SoC credit count out of range"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n) soc_credit |-> ready_for_mb_processing)
        else begin $error("credit before boot completed"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n)
        brkpoint && !ready_for_mb_processing |=> !ready_for_mb_processing)
        else begin $error("break point did not hold boot"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n) soc_rd_en |-> ##2 soc_rd_valid)
        else begin $error("read data late"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n) soc_rd_valid |-> $past(soc_rd_en, 2))
        else begin $error("read data without a request"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n) mailbox_data_avail |-> !mbox_sram_we)
        else begin $error("SRAM write while mailbox full"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n)
        soc_rd_valid && (^mbox_sram_rdata) |=> error_fatal)
        else begin $error("parity error not flagged"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(error_fatal) |-> $past(soc_rd_valid && (^mbox_sram_rdata)))
        else begin $error("fatal error without parity fault"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n) error_fatal |=> error_fatal)
        else begin $error("fatal error cleared"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n)
        fuse_wr && !ready_for_fuses |=> error_non_fatal)
        else begin $error("locked fuse write not flagged"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(error_non_fatal) |-> $past(fuse_wr && !ready_for_fuses))
        else begin $error("non-fatal error without cause"); fail_count = fail_count + 1; end
    assert property (@(posedge clk) disable iff (!rst_n) error_non_fatal |=> error_non_fatal)
        else begin $error("non-fatal error cleared"); fail_count = fail_count + 1; end

endmodule

/* mbox_top_tb.sv */
// Drives boot, two messages, back-pressure, a parity fault and a late fuse write
// Read data is compared with a local copy of each message
module mbox_top_tb
    import mbox_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          RESET_CYCLES    = 16;
    localparam int          MSG_WORDS       = 20;
    localparam int          WATCHDOG_CYCLES = (MSG_WORDS + MSG_WORDS + 2) * 10 + 2000;
    localparam logic [31:0] LCG_SEED        = 32'hf621_1907;

    logic                   core_clk = 1'b0;
    logic                   rst_n;
    logic                   fuse_wr;
    logic                   fuse_done;
    logic                   brkpoint;
    logic                   ready_for_fuses;
    logic                   ready_for_mb_processing;
    logic                   soc_valid = 1'b0;
    logic [MBOX_DATA_W-1:0] soc_data  = '0;
    logic                   soc_last  = 1'b0;
    logic                   soc_credit;
    logic                   soc_rd_en;
    logic [MBOX_ADDR_W-1:0] soc_rd_addr;
    logic                   soc_rd_done;
    logic                   soc_rd_valid;
    logic [MBOX_DATA_W-1:0] soc_rd_data;
    logic                   mailbox_data_avail;
    logic                   mbox_sram_cs;
    logic                   mbox_sram_we;
    logic [MBOX_ADDR_W-1:0] mbox_sram_addr;
    logic [MBOX_SRAM_W-1:0] mbox_sram_wdata;
    logic [MBOX_SRAM_W-1:0] mbox_sram_rdata;
    logic                   error_fatal;
    logic                   error_non_fatal;
    logic                   flip_en;
    logic [MBOX_ADDR_W-1:0] flip_addr;

    logic [MBOX_DATA_W:0]   tx_q [$];
    logic [MBOX_DATA_W-1:0] exp_words [MSG_WORDS];
    logic [31:0]            lcg_state = LCG_SEED;
    int                     tb_crd    = 0;
    int                     sent_cnt  = 0;
    int                     errors    = 0;

    always #20 core_clk = ~core_clk;

    mbox_top dut (
        .clk (core_clk),
        .*
    );

    mbox_tb_services u_sram (
        .clk       (core_clk),
        .cs        (mbox_sram_cs),
        .we        (mbox_sram_we),
        .addr      (mbox_sram_addr),
        .wdata     (mbox_sram_wdata),
        .rdata     (mbox_sram_rdata),
        .flip_en   (flip_en),
        .flip_addr (flip_addr)
    );

    bind mbox_top mbox_top_assertions u_assertions (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // A credit seen now is usable from the next falling edge
    always @(negedge core_clk)
    begin
        if (tb_crd > 0 && tx_q.size() > 0)
        begin
            {soc_last, soc_data} = tx_q.pop_front();
            soc_valid = 1'b1;
            tb_crd    = tb_crd - 1;
            sent_cnt  = sent_cnt + 1;
        end
        else
        begin
            soc_valid = 1'b0;
            soc_last  = 1'b0;
        end
        tb_crd = tb_crd + int'(soc_credit);
    end

    task automatic queue_msg(input int n);
        for (int i = 0; i < n; i++)
        begin
            lcg_state    = lcg_next(lcg_state);
            exp_words[i] = lcg_state;
            tx_q.push_back({i == n - 1, lcg_state});
        end
    endtask

    task automatic strobe_fuse(input logic wr, input logic done);
        fuse_wr   = wr;
        fuse_done = done;
        @(negedge core_clk);
        fuse_wr   = 1'b0;
        fuse_done = 1'b0;
    endtask

    task automatic check_value(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("error: %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic read_check(input string name, input int addr, input logic [31:0] exp);
        @(negedge core_clk);
        soc_rd_en   = 1'b1;
        soc_rd_addr = MBOX_ADDR_W'(addr);
        @(negedge core_clk);
        soc_rd_en = 1'b0;
        while (!soc_rd_valid)
            @(negedge core_clk);
        if (soc_rd_data !== exp)
        begin
            $display("error: %s addr %0d expected %h actual %h", name, addr, exp, soc_rd_data);
            errors++;
        end
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge core_clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        rst_n       = 1'b0;
        fuse_wr     = 1'b0;
        fuse_done   = 1'b0;
        brkpoint    = 1'b0;
        soc_rd_en   = 1'b0;
        soc_rd_addr = '0;
        soc_rd_done = 1'b0;
        flip_en     = 1'b0;
        flip_addr   = '0;
        repeat (RESET_CYCLES) @(posedge core_clk);
        @(negedge core_clk);
        rst_n = 1'b1;

        // Early fuse_done first and then the break point
        while (!ready_for_fuses)
            @(negedge core_clk);
        repeat (FUSE_WORDS - 1) strobe_fuse(1'b1, 1'b0);
        strobe_fuse(1'b0, 1'b1);
        check_value("boot early fuse_done", 1, int'(ready_for_fuses));
        strobe_fuse(1'b1, 1'b0);
        brkpoint = 1'b1;
        strobe_fuse(1'b0, 1'b1);
        check_value("boot fuses closed", 0, int'(ready_for_fuses));
        repeat (3) @(negedge core_clk);
        check_value("boot break point", 0, int'(ready_for_mb_processing));
        brkpoint = 1'b0;
        while (!ready_for_mb_processing)
            @(negedge core_clk);

        queue_msg(MSG_WORDS);
        while (!mailbox_data_avail)
            @(negedge core_clk);
        for (int i = 0; i < MSG_WORDS; i++)
            read_check("msg1", i, exp_words[i]);

        // Second message while the first is still pending
        sent_cnt = 0;
        queue_msg(MSG_WORDS);
        while (sent_cnt < RX_DEPTH + CTRL_CREDITS)
            @(negedge core_clk);
        repeat (10) @(negedge core_clk);
        check_value("backpressure words", RX_DEPTH + CTRL_CREDITS, sent_cnt);
        soc_rd_done = 1'b1;
        @(negedge core_clk);
        soc_rd_done = 1'b0;
        while (!mailbox_data_avail)
            @(negedge core_clk);
        for (int i = 0; i < MSG_WORDS; i++)
            read_check("msg2", i, exp_words[i]);

        flip_en   = 1'b1;
        flip_addr = MBOX_ADDR_W'(5);
        @(negedge core_clk);
        flip_en = 1'b0;
        read_check("parity clean", 3, exp_words[3]);
        @(negedge core_clk);
        check_value("parity clean fatal", 0, int'(error_fatal));
        read_check("parity hit", 5, exp_words[5]);
        @(negedge core_clk);
        check_value("parity hit fatal", 1, int'(error_fatal));

        strobe_fuse(1'b1, 1'b0);
        check_value("fuse lock", 1, int'(error_non_fatal));
        repeat (4) @(negedge core_clk);

        $display("errors: %0d compare, %0d assertion", errors, dut.u_assertions.fail_count);
        if (errors == 0 && dut.u_assertions.fail_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* all.f */
mbox_pkg.sv
mbox_credit_if.sv
soc_ifc_rx.sv
boot_fsm.sv
mbox_ctrl.sv
mbox_top.sv
mbox_tb_services.sv
mbox_top_assertions.sv
mbox_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = mbox_top_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
